// ==== Bender.yml ====
package:
  name: fifo_to_axil

sources:
  - include_dirs:
      - common
    files:
      - common/axil_bridge_pkg.sv
      - flit/flit_deserializer.sv
      - flit/flit_serializer.sv
      - logic/credit_counter.sv
      - axil/axil_master_fsm.sv
      - logic/fifo_to_axil.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/tb_fifo_to_axil.sv

// ==== axil/axil_master_fsm.sv ====
`timescale 1ns/10ps

`include "axil_bridge_settings.svh"

module axil_master_fsm (
  input  logic                       clk_i,
  input  logic                       arst_n_i,

  input  axil_bridge_pkg::axil_msg_s msg_i,
  input  logic                       msg_v_i,
  output logic                       msg_ready_o,

  output axil_bridge_pkg::axil_msg_s ret_o,
  output logic                       ret_v_o,
  input  logic                       ret_ready_i,

  output axil_bridge_pkg::axil_req_s axil_req_o,
  input  axil_bridge_pkg::axil_rsp_s axil_rsp_i,

  output logic                       done_o
);
  import axil_bridge_pkg::*;

  localparam int STRB_W = `AXIL_DATA_WIDTH / 8;

  typedef enum logic [2:0] {
    IDLE,
    WR_ADDR_DATA,
    WR_RESP,
    RD_ADDR,
    RD_DATA,
    RD_RET
  } state_e;

  state_e state_q;

  logic awvalid_q;
  logic wvalid_q;
  logic aw_done;
  logic w_done;

  axil_msg_s                   msg_q;
  logic [`AXIL_DATA_WIDTH-1:0] rdata_q;
  logic [1:0]                  rresp_q;

  logic [STRB_W-1:0]           strb_base;
  logic [`AXIL_DATA_WIDTH-1:0] rd_mask;
  logic [4:0]                  lane_shift;

  assign lane_shift = {msg_q.addr[1:0], 3'b000};

  // Lane masks for the access size, before the byte offset
  always_comb begin
    case (msg_q.size)
      SIZE_1: begin
        strb_base = STRB_W'(4'b0001);
        rd_mask   = `AXIL_DATA_WIDTH'(32'h0000_00ff);
      end
      SIZE_2: begin
        strb_base = STRB_W'(4'b0011);
        rd_mask   = `AXIL_DATA_WIDTH'(32'h0000_ffff);
      end
      default: begin
        strb_base = '1;
        rd_mask   = '1;
      end
    endcase
  end

  assign axil_req_o.awaddr  = msg_q.addr;
  assign axil_req_o.awvalid = awvalid_q;
  assign axil_req_o.wdata   = msg_q.data << lane_shift;
  assign axil_req_o.wstrb   = strb_base << msg_q.addr[1:0];
  assign axil_req_o.wvalid  = wvalid_q;
  assign axil_req_o.bready  = (state_q == WR_RESP);
  assign axil_req_o.araddr  = msg_q.addr;
  assign axil_req_o.arvalid = (state_q == RD_ADDR);
  assign axil_req_o.rready  = (state_q == RD_DATA);

  assign msg_ready_o = (state_q == IDLE);

  assign ret_v_o = (state_q == RD_RET);
  assign ret_o   = '{data:     rdata_q,
                     addr:     msg_q.addr,
                     tag:      msg_q.tag,
                     resp:     {6'b0, rresp_q},
                     size:     msg_q.size,
                     msg_type: MSG_RD_RET};

  assign done_o = ((state_q == WR_RESP) && axil_rsp_i.bvalid)
               || ((state_q == RD_RET) && ret_ready_i);

  // Channel finished this cycle or earlier
  assign aw_done = !awvalid_q || axil_rsp_i.awready;
  assign w_done  = !wvalid_q || axil_rsp_i.wready;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= IDLE;
      awvalid_q <= 1'b0;
      wvalid_q  <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (msg_v_i) begin
            // Anything that is not a write goes down the read path
            if (msg_i.msg_type == MSG_WR) begin
              state_q   <= WR_ADDR_DATA;
              awvalid_q <= 1'b1;
              wvalid_q  <= 1'b1;
            end else begin
              state_q <= RD_ADDR;
            end
          end
        end
        WR_ADDR_DATA: begin
          if (axil_rsp_i.awready) begin
            awvalid_q <= 1'b0;
          end
          if (axil_rsp_i.wready) begin
            wvalid_q <= 1'b0;
          end
          if (aw_done && w_done) begin
            state_q <= WR_RESP;
          end
        end
        WR_RESP: begin
          if (axil_rsp_i.bvalid) begin
            state_q <= IDLE;
          end
        end
        RD_ADDR: begin
          if (axil_rsp_i.arready) begin
            state_q <= RD_DATA;
          end
        end
        RD_DATA: begin
          if (axil_rsp_i.rvalid) begin
            state_q <= RD_RET;
          end
        end
        RD_RET: begin
          if (ret_ready_i) begin
            state_q <= IDLE;
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (msg_v_i && msg_ready_o) begin
      msg_q <= msg_i;
    end
    if ((state_q == RD_DATA) && axil_rsp_i.rvalid) begin
      rdata_q <= (axil_rsp_i.rdata >> lane_shift) & rd_mask;
      rresp_q <= axil_rsp_i.rresp;
    end
  end

endmodule

// ==== common/axil_bridge_pkg.sv ====
`include "axil_bridge_settings.svh"

package axil_bridge_pkg;

  typedef enum logic [7:0] {
    MSG_RD     = 8'h00,
    MSG_WR     = 8'h01,
    MSG_RD_RET = 8'h02
  } msg_type_e;

  // log2 of the byte count
  typedef enum logic [7:0] {
    SIZE_1 = 8'h00,
    SIZE_2 = 8'h01,
    SIZE_4 = 8'h02
  } msg_size_e;

  // First field listed is the most significant
  typedef struct packed {
    logic [`AXIL_DATA_WIDTH-1:0] data;
    logic [`AXIL_ADDR_WIDTH-1:0] addr;
    logic [7:0]                  tag;
    logic [7:0]                  resp;
    msg_size_e                   size;
    msg_type_e                   msg_type;
  } axil_msg_s;

  localparam int MSG_FLITS = $bits(axil_msg_s) / `FLIT_WIDTH;

  typedef struct packed {
    logic [`AXIL_ADDR_WIDTH-1:0]   awaddr;
    logic                          awvalid;
    logic [`AXIL_DATA_WIDTH-1:0]   wdata;
    logic [`AXIL_DATA_WIDTH/8-1:0] wstrb;
    logic                          wvalid;
    logic                          bready;
    logic [`AXIL_ADDR_WIDTH-1:0]   araddr;
    logic                          arvalid;
    logic                          rready;
  } axil_req_s;

  typedef struct packed {
    logic                        awready;
    logic                        wready;
    logic [1:0]                  bresp;
    logic                        bvalid;
    logic                        arready;
    logic [`AXIL_DATA_WIDTH-1:0] rdata;
    logic [1:0]                  rresp;
    logic                        rvalid;
  } axil_rsp_s;

endpackage

// ==== common/axil_bridge_settings.svh ====
`ifndef AXIL_BRIDGE_SETTINGS_SVH
`define AXIL_BRIDGE_SETTINGS_SVH

// Flit stream width
`define FLIT_WIDTH 16

// AXI4-Lite bus widths
`define AXIL_ADDR_WIDTH 32
`define AXIL_DATA_WIDTH 32

// Outstanding request limit and the counter width it needs
`define NUM_CREDITS 4
`define CREDIT_CNT_WIDTH $clog2(`NUM_CREDITS + 1)

`endif

// ==== flit/flit_deserializer.sv ====
`timescale 1ns/10ps

`include "axil_bridge_settings.svh"

module flit_deserializer (
  input  logic                       clk_i,
  input  logic                       arst_n_i,

  input  logic [`FLIT_WIDTH-1:0]     flit_i,
  input  logic                       flit_v_i,
  output logic                       flit_ready_o,

  output axil_bridge_pkg::axil_msg_s msg_o,
  output logic                       msg_v_o,
  input  logic                       msg_ready_i
);
  import axil_bridge_pkg::*;

  localparam int MSG_W = $bits(axil_msg_s);
  localparam int CNT_W = $clog2(MSG_FLITS + 1);

  logic [CNT_W-1:0] cnt_q;
  logic [MSG_W-1:0] shift_q;

  assign msg_v_o      = (cnt_q == CNT_W'(MSG_FLITS));
  assign flit_ready_o = !msg_v_o;
  assign msg_o        = shift_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else if (msg_v_o && msg_ready_i) begin
      cnt_q <= '0;
    end else if (flit_v_i && flit_ready_o) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // New flits enter at the top, so the first one ends up lowest
  always_ff @(posedge clk_i) begin
    if (flit_v_i && flit_ready_o) begin
      shift_q <= {flit_i, shift_q[MSG_W-1:`FLIT_WIDTH]};
    end
  end

endmodule

// ==== flit/flit_serializer.sv ====
`timescale 1ns/10ps

`include "axil_bridge_settings.svh"

module flit_serializer (
  input  logic                       clk_i,
  input  logic                       arst_n_i,

  input  axil_bridge_pkg::axil_msg_s msg_i,
  input  logic                       msg_v_i,
  output logic                       msg_ready_o,

  output logic [`FLIT_WIDTH-1:0]     flit_o,
  output logic                       flit_v_o,
  input  logic                       flit_ready_i
);
  import axil_bridge_pkg::*;

  localparam int MSG_W = $bits(axil_msg_s);
  localparam int CNT_W = $clog2(MSG_FLITS + 1);

  // Flits still to be sent
  logic [CNT_W-1:0] left_q;
  logic [MSG_W-1:0] shift_q;

  assign msg_ready_o = (left_q == '0);
  assign flit_v_o    = !msg_ready_o;
  assign flit_o      = shift_q[`FLIT_WIDTH-1:0];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      left_q <= '0;
    end else if (msg_v_i && msg_ready_o) begin
      left_q <= CNT_W'(MSG_FLITS);
    end else if (flit_v_o && flit_ready_i) begin
      left_q <= left_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (msg_v_i && msg_ready_o) begin
      shift_q <= msg_i;
    end else if (flit_v_o && flit_ready_i) begin
      shift_q <= shift_q >> `FLIT_WIDTH;
    end
  end

endmodule

// ==== logic/credit_counter.sv ====
`timescale 1ns/10ps

`include "axil_bridge_settings.svh"

module credit_counter (
  input  logic                         clk_i,
  input  logic                         arst_n_i,

  input  logic                         req_i,
  input  logic                         done_i,
  output logic [`CREDIT_CNT_WIDTH-1:0] count_o
);

  logic [`CREDIT_CNT_WIDTH-1:0] count_q;

  assign count_o = count_q;

  // Both pulses together leave the count alone
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      count_q <= '0;
    end else if (req_i && !done_i && (count_q != `CREDIT_CNT_WIDTH'(`NUM_CREDITS))) begin
      count_q <= count_q + 1'b1;
    end else if (done_i && !req_i && (count_q != '0)) begin
      count_q <= count_q - 1'b1;
    end
  end

endmodule

// ==== logic/fifo_to_axil.sv ====
`timescale 1ns/10ps

`include "axil_bridge_settings.svh"

module fifo_to_axil (
  input  logic                          clk_i,
  input  logic                          arst_n_i,

  input  logic [`FLIT_WIDTH-1:0]        fifo_i,
  input  logic                          fifo_v_i,
  output logic                          fifo_ready_and_o,

  output logic [`FLIT_WIDTH-1:0]        fifo_o,
  output logic                          fifo_v_o,
  input  logic                          fifo_ready_and_i,

  output logic [`AXIL_ADDR_WIDTH-1:0]   m_axil_awaddr_o,
  output logic [2:0]                    m_axil_awprot_o,
  output logic                          m_axil_awvalid_o,
  input  logic                          m_axil_awready_i,

  output logic [`AXIL_DATA_WIDTH-1:0]   m_axil_wdata_o,
  output logic [`AXIL_DATA_WIDTH/8-1:0] m_axil_wstrb_o,
  output logic                          m_axil_wvalid_o,
  input  logic                          m_axil_wready_i,

  input  logic [1:0]                    m_axil_bresp_i,
  input  logic                          m_axil_bvalid_i,
  output logic                          m_axil_bready_o,

  output logic [`AXIL_ADDR_WIDTH-1:0]   m_axil_araddr_o,
  output logic [2:0]                    m_axil_arprot_o,
  output logic                          m_axil_arvalid_o,
  input  logic                          m_axil_arready_i,

  input  logic [`AXIL_DATA_WIDTH-1:0]   m_axil_rdata_i,
  input  logic [1:0]                    m_axil_rresp_i,
  input  logic                          m_axil_rvalid_i,
  output logic                          m_axil_rready_o,

  output logic [`CREDIT_CNT_WIDTH-1:0]  credits_used_o
);
  import axil_bridge_pkg::*;

  axil_msg_s req_msg;
  logic      req_msg_v;
  logic      req_msg_ready;
  axil_msg_s ret_msg;
  logic      ret_msg_v;
  logic      ret_msg_ready;
  axil_req_s axil_req;
  axil_rsp_s axil_rsp;
  logic      done;

  flit_deserializer i_deser (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .flit_i       (fifo_i),
    .flit_v_i     (fifo_v_i),
    .flit_ready_o (fifo_ready_and_o),
    .msg_o        (req_msg),
    .msg_v_o      (req_msg_v),
    .msg_ready_i  (req_msg_ready)
  );

  axil_master_fsm i_fsm (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .msg_i       (req_msg),
    .msg_v_i     (req_msg_v),
    .msg_ready_o (req_msg_ready),
    .ret_o       (ret_msg),
    .ret_v_o     (ret_msg_v),
    .ret_ready_i (ret_msg_ready),
    .axil_req_o  (axil_req),
    .axil_rsp_i  (axil_rsp),
    .done_o      (done)
  );

  flit_serializer i_ser (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .msg_i        (ret_msg),
    .msg_v_i      (ret_msg_v),
    .msg_ready_o  (ret_msg_ready),
    .flit_o       (fifo_o),
    .flit_v_o     (fifo_v_o),
    .flit_ready_i (fifo_ready_and_i)
  );

  // One credit per message handed to the FSM
  credit_counter i_credits (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (req_msg_v && req_msg_ready),
    .done_i   (done),
    .count_o  (credits_used_o)
  );

  assign axil_rsp = '{awready: m_axil_awready_i,
                      wready:  m_axil_wready_i,
                      bresp:   m_axil_bresp_i,
                      bvalid:  m_axil_bvalid_i,
                      arready: m_axil_arready_i,
                      rdata:   m_axil_rdata_i,
                      rresp:   m_axil_rresp_i,
                      rvalid:  m_axil_rvalid_i};

  assign m_axil_awaddr_o  = axil_req.awaddr;
  assign m_axil_awvalid_o = axil_req.awvalid;
  assign m_axil_wdata_o   = axil_req.wdata;
  assign m_axil_wstrb_o   = axil_req.wstrb;
  assign m_axil_wvalid_o  = axil_req.wvalid;
  assign m_axil_bready_o  = axil_req.bready;
  assign m_axil_araddr_o  = axil_req.araddr;
  assign m_axil_arvalid_o = axil_req.arvalid;
  assign m_axil_rready_o  = axil_req.rready;

  // Unprivileged secure data access
  assign m_axil_awprot_o = 3'b000;
  assign m_axil_arprot_o = 3'b000;

endmodule

// ==== tb.f ====
+incdir+common
common/axil_bridge_pkg.sv
flit/flit_deserializer.sv
flit/flit_serializer.sv
logic/credit_counter.sv
axil/axil_master_fsm.sv
logic/fifo_to_axil.sv
tests/tb_fifo_to_axil.sv

// ==== tests/tb_fifo_to_axil.sv ====
`timescale 1ns/10ps

`include "axil_bridge_settings.svh"

module tb_fifo_to_axil;
  import axil_bridge_pkg::*;

  localparam int STRB_W = `AXIL_DATA_WIDTH / 8;
  localparam logic [`AXIL_ADDR_WIDTH-1:0] ERR_BASE = 32'h0000_0800;
  // Longest test is well under 2000 cycles, with a margin of ten
  localparam int WORST_TEST_CYCLES = 2000;
  localparam int TIMEOUT_CYCLES = 10 * WORST_TEST_CYCLES;
  localparam int STALL_CYCLES = 20;

  logic clk;
  logic arst_n;
  logic [`FLIT_WIDTH-1:0] fifo_in;
  logic fifo_in_v;
  logic fifo_in_ready;
  logic [`FLIT_WIDTH-1:0] fifo_out;
  logic fifo_out_v;
  logic fifo_out_ready;
  logic [`AXIL_ADDR_WIDTH-1:0] awaddr;
  logic [2:0] awprot;
  logic awvalid;
  logic awready;
  logic [`AXIL_DATA_WIDTH-1:0] wdata;
  logic [STRB_W-1:0] wstrb;
  logic wvalid;
  logic wready;
  logic [1:0] bresp;
  logic bvalid;
  logic bready;
  logic [`AXIL_ADDR_WIDTH-1:0] araddr;
  logic [2:0] arprot;
  logic arvalid;
  logic arready;
  logic [`AXIL_DATA_WIDTH-1:0] rdata;
  logic [1:0] rresp;
  logic rvalid;
  logic rready;
  logic [`CREDIT_CNT_WIDTH-1:0] credits_used;

  logic [`AXIL_DATA_WIDTH-1:0] mem [256];
  logic [`AXIL_DATA_WIDTH-1:0] ref_mem [256];
  logic [STRB_W-1:0] last_wstrb;
  integer seed = 32'h7a5f;
  int err_count = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int ret_valid_cycles = 0;
  int cycle_cnt = 0;

  fifo_to_axil i_dut (
    .clk_i            (clk),
    .arst_n_i         (arst_n),
    .fifo_i           (fifo_in),
    .fifo_v_i         (fifo_in_v),
    .fifo_ready_and_o (fifo_in_ready),
    .fifo_o           (fifo_out),
    .fifo_v_o         (fifo_out_v),
    .fifo_ready_and_i (fifo_out_ready),
    .m_axil_awaddr_o  (awaddr),
    .m_axil_awprot_o  (awprot),
    .m_axil_awvalid_o (awvalid),
    .m_axil_awready_i (awready),
    .m_axil_wdata_o   (wdata),
    .m_axil_wstrb_o   (wstrb),
    .m_axil_wvalid_o  (wvalid),
    .m_axil_wready_i  (wready),
    .m_axil_bresp_i   (bresp),
    .m_axil_bvalid_i  (bvalid),
    .m_axil_bready_o  (bready),
    .m_axil_araddr_o  (araddr),
    .m_axil_arprot_o  (arprot),
    .m_axil_arvalid_o (arvalid),
    .m_axil_arready_i (arready),
    .m_axil_rdata_i   (rdata),
    .m_axil_rresp_i   (rresp),
    .m_axil_rvalid_i  (rvalid),
    .m_axil_rready_o  (rready),
    .credits_used_o   (credits_used)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin : watchdog
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

  always @(posedge clk) begin
    if (fifo_out_v) begin
      ret_valid_cycles <= ret_valid_cycles + 1;
    end
  end

  task automatic random_wait();
    int n;
    n = $unsigned($random(seed)) % 4;
    repeat (n) @(posedge clk);
  endtask

  // Slave side, AW then W then B
  initial begin : write_slave
    logic [`AXIL_ADDR_WIDTH-1:0] addr;
    logic [`AXIL_DATA_WIDTH-1:0] data;
    logic [STRB_W-1:0] strb;
    awready = 1'b0;
    wready = 1'b0;
    bvalid = 1'b0;
    bresp = 2'b00;
    forever begin
      @(posedge clk);
      if (awvalid) begin
        random_wait();
        awready <= 1'b1;
        @(posedge clk);
        addr = awaddr;
        check_prot("write address prot", awprot, 3'b000);
        awready <= 1'b0;
        random_wait();
        wready <= 1'b1;
        @(posedge clk);
        data = wdata;
        strb = wstrb;
        wready <= 1'b0;
        last_wstrb = strb;
        if (addr < ERR_BASE) begin
          for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) begin
              mem[addr[9:2]][b*8 +: 8] = data[b*8 +: 8];
            end
          end
        end
        random_wait();
        bvalid <= 1'b1;
        bresp <= (addr < ERR_BASE) ? 2'd0 : 2'd2;
        @(posedge clk);
        while (!bready) @(posedge clk);
        bvalid <= 1'b0;
      end
    end
  end

  initial begin : read_slave
    logic [`AXIL_ADDR_WIDTH-1:0] addr;
    arready = 1'b0;
    rvalid = 1'b0;
    rdata = '0;
    rresp = 2'b00;
    forever begin
      @(posedge clk);
      if (arvalid) begin
        random_wait();
        arready <= 1'b1;
        @(posedge clk);
        addr = araddr;
        check_prot("read address prot", arprot, 3'b000);
        arready <= 1'b0;
        random_wait();
        rvalid <= 1'b1;
        rdata <= (addr < ERR_BASE) ? mem[addr[9:2]] : '0;
        rresp <= (addr < ERR_BASE) ? 2'd0 : 2'd2;
        @(posedge clk);
        while (!rready) @(posedge clk);
        rvalid <= 1'b0;
      end
    end
  end

  function automatic axil_msg_s make_msg(msg_type_e t, msg_size_e s, logic [7:0] tag,
                                         logic [31:0] addr, logic [31:0] data);
    axil_msg_s m;
    m.msg_type = t;
    m.size = s;
    m.resp = 8'h00;
    m.tag = tag;
    m.addr = addr;
    m.data = data;
    return m;
  endfunction

  // Byte-wise model of a write into the reference memory
  function automatic void ref_write(axil_msg_s req);
    int nbytes;
    nbytes = 1 << req.size;
    if (req.addr < ERR_BASE) begin
      for (int i = 0; i < nbytes; i++) begin
        ref_mem[req.addr[9:2]][(req.addr[1:0] + i)*8 +: 8] = req.data[i*8 +: 8];
      end
    end
  endfunction

  function automatic axil_msg_s expected_return(axil_msg_s req);
    axil_msg_s m;
    int nbytes;
    m = req;
    m.msg_type = MSG_RD_RET;
    m.data = '0;
    nbytes = 1 << req.size;
    if (req.addr >= ERR_BASE) begin
      m.resp = 8'd2;
    end else begin
      m.resp = 8'd0;
      for (int i = 0; i < nbytes; i++) begin
        m.data[i*8 +: 8] = ref_mem[req.addr[9:2]][(req.addr[1:0] + i)*8 +: 8];
      end
    end
    return m;
  endfunction

  task automatic send_msg(input axil_msg_s m);
    int i;
    i = 0;
    while (i < MSG_FLITS) begin
      fifo_in <= m[i*`FLIT_WIDTH +: `FLIT_WIDTH];
      fifo_in_v <= 1'b1;
      @(posedge clk);
      if (fifo_in_ready) begin
        i++;
      end
    end
    fifo_in_v <= 1'b0;
  endtask

  task automatic recv_msg(output axil_msg_s m);
    int i;
    i = 0;
    m = '0;
    while (i < MSG_FLITS) begin
      @(posedge clk);
      if (fifo_out_v && fifo_out_ready) begin
        m[i*`FLIT_WIDTH +: `FLIT_WIDTH] = fifo_out;
        i++;
      end
    end
  endtask

  // Nothing held in the deserializer and no credit outstanding
  task automatic wait_drained();
    @(posedge clk);
    while (credits_used != '0 || !fifo_in_ready) @(posedge clk);
  endtask

  task automatic check_msg(string what, axil_msg_s got, axil_msg_s exp);
    if (got !== exp) begin
      $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
      err_count++;
    end
  endtask

  task automatic check_credits(string what, logic [`CREDIT_CNT_WIDTH-1:0] got,
                               logic [`CREDIT_CNT_WIDTH-1:0] exp);
    if (got !== exp) begin
      $display("FAIL %0t: %s got %0d expected %0d", $time, what, got, exp);
      err_count++;
    end
  endtask

  task automatic check_strb(string what, logic [STRB_W-1:0] got, logic [STRB_W-1:0] exp);
    if (got !== exp) begin
      $display("FAIL %0t: %s got %b expected %b", $time, what, got, exp);
      err_count++;
    end
  endtask

  task automatic check_prot(string what, logic [2:0] got, logic [2:0] exp);
    if (got !== exp) begin
      $display("FAIL %0t: %s got %b expected %b", $time, what, got, exp);
      err_count++;
    end
  endtask

  task automatic report_test(string name, int start_err);
    tests_run++;
    if (err_count == start_err) begin
      $display("Test %s passed", name);
    end else begin
      tests_failed++;
      $display("Test %s failed with %0d errors", name, err_count - start_err);
    end
  endtask

  task automatic test_reset_state();
    int start_err;
    start_err = err_count;
    check_credits("credits after reset", credits_used, '0);
    if (!fifo_in_ready || fifo_out_v || awvalid || wvalid || bready || arvalid || rready) begin
      $display("Outputs were not idle after reset at %0t", $time);
      err_count++;
    end
    report_test("reset_state", start_err);
  endtask

  task automatic test_word_write_read();
    int start_err;
    axil_msg_s wr;
    axil_msg_s rd;
    axil_msg_s got;
    start_err = err_count;
    wr = make_msg(MSG_WR, SIZE_4, 8'h11, 32'h40, 32'h1357_9bdf);
    rd = make_msg(MSG_RD, SIZE_4, 8'h12, 32'h40, '0);
    ref_write(wr);
    send_msg(wr);
    wait_drained();
    check_strb("word write strobes", last_wstrb, 4'b1111);
    send_msg(rd);
    recv_msg(got);
    check_msg("word read return", got, expected_return(rd));
    wait_drained();
    report_test("word_write_read", start_err);
  endtask

  task automatic test_subword_write();
    int start_err;
    axil_msg_s wr_b;
    axil_msg_s wr_h;
    axil_msg_s rd_w;
    axil_msg_s rd_b;
    axil_msg_s got;
    start_err = err_count;
    wr_b = make_msg(MSG_WR, SIZE_1, 8'h21, 32'h13, 32'h0000_00a5);
    wr_h = make_msg(MSG_WR, SIZE_2, 8'h22, 32'h10, 32'hdead_1234);
    rd_w = make_msg(MSG_RD, SIZE_4, 8'h23, 32'h10, '0);
    rd_b = make_msg(MSG_RD, SIZE_1, 8'h24, 32'h13, '0);
    ref_write(wr_b);
    send_msg(wr_b);
    wait_drained();
    check_strb("byte 3 write strobes", last_wstrb, 4'b1000);
    ref_write(wr_h);
    send_msg(wr_h);
    wait_drained();
    check_strb("half at byte 0 strobes", last_wstrb, 4'b0011);
    send_msg(rd_w);
    recv_msg(got);
    check_msg("merged word read", got, expected_return(rd_w));
    send_msg(rd_b);
    recv_msg(got);
    check_msg("byte 3 read", got, expected_return(rd_b));
    wait_drained();
    report_test("subword_write", start_err);
  endtask

  task automatic test_write_no_return();
    int start_err;
    int seen_before;
    axil_msg_s wr;
    start_err = err_count;
    seen_before = ret_valid_cycles;
    for (int n = 0; n < 2; n++) begin
      wr = make_msg(MSG_WR, SIZE_4, 8'h30 + n, 32'h100 + 4*n, 32'h0bad_f00d + n);
      ref_write(wr);
      send_msg(wr);
      // Handoff one cycle after the last flit, count one cycle later
      repeat (2) @(posedge clk);
      check_credits("credits after write", credits_used, 1);
      wait_drained();
    end
    if (ret_valid_cycles != seen_before) begin
      $display("A write produced return flits at %0t", $time);
      err_count++;
    end
    report_test("write_no_return", start_err);
  endtask

  task automatic test_back_pressure();
    int start_err;
    axil_msg_s rd_a;
    axil_msg_s rd_b;
    axil_msg_s got;
    logic [`FLIT_WIDTH-1:0] held;
    start_err = err_count;
    rd_a = make_msg(MSG_RD, SIZE_4, 8'h41, 32'h40, '0);
    rd_b = make_msg(MSG_RD, SIZE_4, 8'h42, 32'h80, '0);
    fifo_out_ready <= 1'b0;
    send_msg(rd_a);
    send_msg(rd_b);
    while (!fifo_out_v) @(posedge clk);
    held = fifo_out;
    repeat (STALL_CYCLES) begin
      @(posedge clk);
      if (!fifo_out_v || fifo_out !== held) begin
        $display("FAIL %0t: flit output changed while stalled", $time);
        err_count++;
      end
    end
    // Second read waits behind the blocked return
    check_credits("credits while stalled", credits_used, 1);
    fifo_out_ready <= 1'b1;
    recv_msg(got);
    check_msg("first stalled return", got, expected_return(rd_a));
    recv_msg(got);
    check_msg("second stalled return", got, expected_return(rd_b));
    wait_drained();
    report_test("back_pressure", start_err);
  endtask

  task automatic test_error_response();
    int start_err;
    axil_msg_s rd;
    axil_msg_s got;
    start_err = err_count;
    rd = make_msg(MSG_RD, SIZE_4, 8'h51, 32'h0000_0900, '0);
    send_msg(rd);
    recv_msg(got);
    check_msg("error read return", got, expected_return(rd));
    wait_drained();
    report_test("error_response", start_err);
  endtask

  task automatic test_outstanding();
    int start_err;
    axil_msg_s rd_a;
    axil_msg_s wr_b;
    axil_msg_s rd_c;
    axil_msg_s exp_a;
    axil_msg_s exp_c;
    axil_msg_s got_a;
    axil_msg_s got_c;
    start_err = err_count;
    rd_a = make_msg(MSG_RD, SIZE_4, 8'h61, 32'h80, '0);
    wr_b = make_msg(MSG_WR, SIZE_4, 8'h62, 32'hc0, 32'h2468_ace0);
    rd_c = make_msg(MSG_RD, SIZE_2, 8'h63, 32'hc2, '0);
    exp_a = expected_return(rd_a);
    ref_write(wr_b);
    exp_c = expected_return(rd_c);
    fork
      begin
        send_msg(rd_a);
        send_msg(wr_b);
        send_msg(rd_c);
      end
      begin
        recv_msg(got_a);
        recv_msg(got_c);
      end
    join
    check_msg("first outstanding read", got_a, exp_a);
    check_msg("read after outstanding write", got_c, exp_c);
    wait_drained();
    report_test("outstanding", start_err);
  endtask

  initial begin : main
    for (int i = 0; i < 256; i++) begin
      mem[i] = {16'hc0de, 16'(i * 4)};
      ref_mem[i] = {16'hc0de, 16'(i * 4)};
    end
    fifo_in = '0;
    fifo_in_v = 1'b0;
    fifo_out_ready = 1'b1;
    arst_n = 1'b0;
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);
    test_reset_state();
    test_word_write_read();
    test_subword_write();
    test_write_no_return();
    test_back_pressure();
    test_error_response();
    test_outstanding();
    $display("Tests run: %0d, failed: %0d, check errors: %0d",
             tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
